// File: filelist.f
source/simd_pkg.sv
source/sdp_bram.sv
source/data_mem.sv
source/inst_issue.sv
source/lane_alu.sv
source/simd_core.sv
testbench/tb_simd_core.sv

// File: source/data_mem.sv
`timescale 1ns/10ps
`default_nettype none

module data_mem (
  input  wire                clk,
  input  wire                rst,
  input  wire                iss_v,
  input  wire simd_pkg::inst_t iss,
  input  wire                wb_v,
  input  wire simd_pkg::data_t wb_data,
  input  wire                load_v,
  input  wire simd_pkg::data_t load_data,
  input  wire                xfer_v,
  input  wire simd_pkg::data_t xfer_data,
  output simd_pkg::data_t    src1_data,
  output simd_pkg::data_t    src2_data
);

  import simd_pkg::*;

  dm_addr_t load_ptr;             // next load word
  dm_addr_t xfer_ptr;             // next transfer word
  dm_addr_t raddr1;               // source 1 read address
  dm_addr_t raddr2;               // source 2 read address
  logic     rd_v;                 // read addresses valid this cycle
  dm_addr_t dst_pipe [WB_LAT];    // destination delay line

  // merged write port, same for both mirrors
  logic     we;
  dm_addr_t waddr;
  data_t    wdata;

  ////////////////////////////////////////////////////////////////////////////
  // host write pointers
  ////////////////////////////////////////////////////////////////////////////

  // each beat advances its pointer even when write-back takes the port
  always_ff @(posedge clk) begin
    if (rst) begin
      load_ptr <= '0;
      xfer_ptr <= XFER_BASE;
    end else begin
      if (load_v) begin
        load_ptr <= load_ptr + 1'b1;   // wraps in 8 bits
      end
      if (xfer_v) begin
        xfer_ptr <= xfer_ptr + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read side
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (iss_v) begin
      raddr2 <= iss.src2;
      raddr1 <= iss.src1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_v <= 1'b0;
    end else begin
      rd_v <= iss_v;   // enables the array read one cycle after issue
    end
  end

  // dst rides along until wb_v shows up at WB_LAT
  always_ff @(posedge clk) begin
    dst_pipe[0] <= iss.dst;
    for (int i = 1; i < WB_LAT; i++) begin
      dst_pipe[i] <= dst_pipe[i-1];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // write port select
  ////////////////////////////////////////////////////////////////////////////

  // write-back first, then load, then transfer
  always_comb begin
    we    = 1'b1;
    waddr = load_ptr;
    wdata = load_data;
    if (wb_v) begin
      waddr = dst_pipe[WB_LAT-1];
      wdata = wb_data;
    end else if (load_v) begin
      waddr = load_ptr;
      wdata = load_data;
    end else if (xfer_v) begin
      waddr = xfer_ptr;
      wdata = xfer_data;
    end else begin
      we = 1'b0;   // idle port
    end
  end

  // mirror_0 serves source 1
  sdp_bram #(
    .WIDTH ($bits(data_t)),
    .DEPTH (DM_DEPTH)
  ) mirror_0 (
    .clk   (clk),
    .rst   (rst),
    .we    (we),
    .waddr (waddr),
    .wdata (wdata),
    .re    (rd_v),
    .raddr (raddr1),
    .rdata (src1_data)
  );

  // mirror_1 serves source 2
  sdp_bram #(
    .WIDTH ($bits(data_t)),
    .DEPTH (DM_DEPTH)
  ) mirror_1 (
    .clk   (clk),
    .rst   (rst),
    .we    (we),
    .waddr (waddr),
    .wdata (wdata),
    .re    (rd_v),
    .raddr (raddr2),
    .rdata (src2_data)
  );

endmodule

`default_nettype wire

// File: source/inst_issue.sv
`timescale 1ns/10ps
`default_nettype none

module inst_issue (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  inst_v,
  input  wire simd_pkg::inst_t inst,
  input  wire                  res_credit,
  output logic                 inst_credit,
  output logic                 iss_v,
  output simd_pkg::inst_t      iss,
  output logic                 busy
);

  import simd_pkg::*;

  inst_t    q_mem [INST_QDEPTH];   // instruction queue
  qptr_t    wr_ptr;
  qptr_t    rd_ptr;
  qcnt_t    q_cnt;                 // occupancy
  logic     q_empty;
  res_cnt_t res_cnt;               // result credits held

  // scoreboard, one slot per cycle in flight
  dm_addr_t          sb_dst [WB_LAT];
  logic [WB_LAT-1:0] sb_v;
  logic              hazard;

  ////////////////////////////////////////////////////////////////////////////
  // queue
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (inst_v) begin
      q_mem[wr_ptr] <= inst;   // host never overruns, it holds the credits
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      q_cnt  <= '0;
    end else begin
      if (inst_v) wr_ptr <= wr_ptr + 1'b1;
      if (iss_v) rd_ptr <= rd_ptr + 1'b1;
      case ({inst_v, iss_v})
        2'b10:   q_cnt <= q_cnt + 1'b1;
        2'b01:   q_cnt <= q_cnt - 1'b1;
        default: q_cnt <= q_cnt;   // push and pop cancel
      endcase
    end
  end

  assign q_empty = (q_cnt == '0);
  assign iss     = q_mem[rd_ptr];   // head

  ////////////////////////////////////////////////////////////////////////////
  // result credits
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      res_cnt <= '0;
    end else if (res_credit && !iss_v && res_cnt != res_cnt_t'(RES_CREDIT_MAX)) begin
      res_cnt <= res_cnt + 1'b1;    // saturating grant
    end else if (!res_credit && iss_v) begin
      res_cnt <= res_cnt - 1'b1;    // one per issue
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // raw hazard check and issue
  ////////////////////////////////////////////////////////////////////////////

  // a source matching any in-flight dst waits
  always_comb begin
    hazard = 1'b0;
    for (int i = 0; i < WB_LAT; i++) begin
      if (sb_v[i] && (sb_dst[i] == iss.src1 || sb_dst[i] == iss.src2)) begin
        hazard = 1'b1;
      end
    end
  end

  assign iss_v       = !q_empty && (res_cnt != '0) && !hazard;
  assign inst_credit = iss_v;   // slot frees on issue

  // entry leaves after WB_LAT cycles, dst is in the ram by then
  always_ff @(posedge clk) begin
    if (rst) begin
      sb_v <= '0;
    end else begin
      sb_v <= {sb_v[WB_LAT-2:0], iss_v};
    end
  end

  always_ff @(posedge clk) begin
    sb_dst[0] <= iss.dst;
    for (int i = 1; i < WB_LAT; i++) begin
      sb_dst[i] <= sb_dst[i-1];
    end
  end

  assign busy = !q_empty || (sb_v != '0);   // queued or in flight

endmodule

`default_nettype wire

// File: source/lane_alu.sv
`timescale 1ns/10ps
`default_nettype none

module lane_alu (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  iss_v,
  input  wire simd_pkg::inst_t iss,
  input  wire simd_pkg::data_t src1_data,
  input  wire simd_pkg::data_t src2_data,
  output logic                 wb_v,
  output simd_pkg::data_t      wb_data,
  output logic                 res_v,
  output simd_pkg::result_t    res
);

  import simd_pkg::*;

  // control delayed to meet the ram output
  logic [RD_LAT-1:0] v_pipe;
  op_e               op_pipe  [RD_LAT];
  dm_addr_t          dst_pipe [RD_LAT];

  data_t   alu_out;
  result_t res_q;     // registered result
  logic    res_v_q;

  // one lane, all ops wrap modulo 2^16
  function automatic lane_t lane_op(input op_e op, input lane_t a, input lane_t b);
    logic [2*LANE_W-1:0] prod;
    prod = a * b;
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_MUL:  return prod[LANE_W-1:0];   // low half
      default: return (a > b) ? a : b;   // OP_MAX, unsigned
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // alignment stages
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      v_pipe <= '0;
    end else begin
      v_pipe <= {v_pipe[RD_LAT-2:0], iss_v};
    end
  end

  always_ff @(posedge clk) begin
    op_pipe[0]  <= iss.op;
    dst_pipe[0] <= iss.dst;
    for (int i = 1; i < RD_LAT; i++) begin
      op_pipe[i]  <= op_pipe[i-1];
      dst_pipe[i] <= dst_pipe[i-1];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // lanes and output register
  ////////////////////////////////////////////////////////////////////////////

  // lanes never carry into each other
  assign alu_out = {
    lane_op(op_pipe[RD_LAT-1], src1_data[2*LANE_W-1:LANE_W], src2_data[2*LANE_W-1:LANE_W]),
    lane_op(op_pipe[RD_LAT-1], src1_data[LANE_W-1:0], src2_data[LANE_W-1:0])
  };

  always_ff @(posedge clk) begin
    if (rst) begin
      res_v_q <= 1'b0;
    end else begin
      res_v_q <= v_pipe[RD_LAT-1];
    end
  end

  always_ff @(posedge clk) begin
    res_q.dst  <= dst_pipe[RD_LAT-1];
    res_q.data <= alu_out;
  end

  // same beat goes back to memory and out to the consumer
  assign wb_v    = res_v_q;
  assign wb_data = res_q.data;
  assign res_v   = res_v_q;
  assign res     = res_q;

endmodule

`default_nettype wire

// File: source/sdp_bram.sv
`timescale 1ns/10ps
`default_nettype none

// simple dual port, one clock
// read is two cycles from raddr to rdata
module sdp_bram #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 256
) (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       we,      // write port
  input  wire [$clog2(DEPTH)-1:0]   waddr,
  input  wire [WIDTH-1:0]           wdata,
  input  wire                       re,      // read port
  input  wire [$clog2(DEPTH)-1:0]   raddr,
  output logic [WIDTH-1:0]          rdata
);

  logic [WIDTH-1:0] mem [DEPTH];   // the array itself
  logic [WIDTH-1:0] rd_q;          // first read stage

  // write and array read share one clock edge
  // a read of the address being written returns the old word
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    if (re) begin
      rd_q <= mem[raddr];
    end
  end

  // output register, the only stage touched by rst
  always_ff @(posedge clk) begin
    if (rst) begin
      rdata <= '0;
    end else begin
      rdata <= rd_q;
    end
  end

endmodule

`default_nettype wire

// File: source/simd_core.sv
`timescale 1ns/10ps
`default_nettype none

module simd_core (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  inst_v,
  input  wire simd_pkg::inst_t inst,
  input  wire                  res_credit,
  input  wire                  load_v,
  input  wire simd_pkg::data_t load_data,
  input  wire                  xfer_v,
  input  wire simd_pkg::data_t xfer_data,
  output logic                 inst_credit,
  output logic                 res_v,
  output simd_pkg::result_t    res,
  output logic                 busy
);

  import simd_pkg::*;

  logic  iss_v;       // issue pulse
  inst_t iss;         // issued instruction
  data_t src1_data;   // operands, RD_LAT after issue
  data_t src2_data;
  logic  wb_v;        // write-back, WB_LAT after issue
  data_t wb_data;

  ////////////////////////////////////////////////////////////////////////////
  // issue, memory, alu
  ////////////////////////////////////////////////////////////////////////////

  inst_issue u_inst_issue (
    .clk         (clk),
    .rst         (rst),
    .inst_v      (inst_v),
    .inst        (inst),
    .res_credit  (res_credit),
    .inst_credit (inst_credit),
    .iss_v       (iss_v),
    .iss         (iss),
    .busy        (busy)
  );

  data_mem u_data_mem (
    .clk       (clk),
    .rst       (rst),
    .iss_v     (iss_v),
    .iss       (iss),
    .wb_v      (wb_v),
    .wb_data   (wb_data),
    .load_v    (load_v),
    .load_data (load_data),
    .xfer_v    (xfer_v),
    .xfer_data (xfer_data),
    .src1_data (src1_data),
    .src2_data (src2_data)
  );

  lane_alu u_lane_alu (
    .clk       (clk),
    .rst       (rst),
    .iss_v     (iss_v),
    .iss       (iss),
    .src1_data (src1_data),
    .src2_data (src2_data),
    .wb_v      (wb_v),
    .wb_data   (wb_data),
    .res_v     (res_v),
    .res       (res)
  );

endmodule

`default_nettype wire

// File: source/simd_pkg.sv
`default_nettype none

package simd_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths and sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int DATA_W = 32;            // one memory word
  localparam int LANE_W = 16;            // two lanes per word
  localparam int ADDR_W = 8;             // data memory address
  localparam int DM_DEPTH = 256;         // words in the data memory

  localparam int INST_QDEPTH = 4;        // queue slots and host credits after reset
  localparam int RES_CREDIT_MAX = 8;     // result credit counter saturates here

  // pipeline depths counted from the issue pulse
  localparam int RD_LAT = 3;             // source data at the alu input
  localparam int WB_LAT = 4;             // write-back and result beat

  localparam int QPTR_W = $clog2(INST_QDEPTH);
  localparam int CRED_W = $clog2(RES_CREDIT_MAX + 1);

  ////////////////////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [LANE_W-1:0] lane_t;
  typedef logic [ADDR_W-1:0] dm_addr_t;
  typedef logic [QPTR_W-1:0] qptr_t;     // queue slot index
  typedef logic [QPTR_W:0]   qcnt_t;     // queue occupancy, 0 to INST_QDEPTH
  typedef logic [CRED_W-1:0] res_cnt_t;  // result credits held

  localparam dm_addr_t XFER_BASE = 8'h8f; // first neighbour-transfer word

  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_MUL = 2'd2,   // low half of the product
    OP_MAX = 2'd3    // unsigned
  } op_e;

  // field order op, src2, src1, dst from msb down
  typedef struct packed {
    op_e      op;
    dm_addr_t src2;
    dm_addr_t src1;
    dm_addr_t dst;
  } inst_t;

  typedef struct packed {
    dm_addr_t dst;
    data_t    data;
  } result_t;

endpackage

`default_nettype wire

// File: testbench/tb_simd_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_simd_core;

  import simd_pkg::*;

  localparam int WAIT_LIMIT = 500;   // cycles per wait loop

  logic    clk;
  logic    rst;
  logic    inst_v;
  inst_t   inst;
  logic    res_credit;
  logic    load_v;
  data_t   load_data;
  logic    xfer_v;
  data_t   xfer_data;
  logic    inst_credit;
  logic    res_v;
  result_t res;
  logic    busy;

  // host side models
  data_t    ref_mem [DM_DEPTH];  // reference data memory
  dm_addr_t tb_load_ptr;
  dm_addr_t tb_xfer_ptr;
  int       host_credits;        // instruction credits held
  int       credit_pulses;       // inst_credit pulses seen
  int       beats;               // res_v beats seen
  result_t  exp_q [$];           // expected results in issue order
  logic     busy_s;              // busy as seen at the last falling edge
  logic [31:0] lfsr;
  int       errors;
  int       checks;

  simd_core i_simd_core (
    .clk         (clk),
    .rst         (rst),
    .inst_v      (inst_v),
    .inst        (inst),
    .res_credit  (res_credit),
    .load_v      (load_v),
    .load_data   (load_data),
    .xfer_v      (xfer_v),
    .xfer_data   (xfer_data),
    .inst_credit (inst_credit),
    .res_v       (res_v),
    .res         (res),
    .busy        (busy)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;   // 4 ns period
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers and reference model
  ////////////////////////////////////////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1, one step per bit taken
  function automatic data_t rand_word();
    data_t w;
    logic  fb;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      w    = {w[30:0], fb};
    end
    return w;
  endfunction

  // one lane, worked out in wide integers and then folded to 16 bits
  function automatic lane_t lane_ref(input op_e op, input lane_t a, input lane_t b);
    longint x;
    longint y;
    longint r;
    x = a;
    y = b;
    case (op)
      OP_ADD:  r = x + y;
      OP_SUB:  r = x - y + 65536;   // keep it positive before the fold
      OP_MUL:  r = x * y;
      default: r = (x >= y) ? x : y;
    endcase
    return lane_t'(r % 65536);
  endfunction

  // runs the instruction on ref_mem in program order
  function automatic result_t model_exec(input inst_t in);
    result_t r;
    data_t   a;
    data_t   b;
    a = ref_mem[in.src1];
    b = ref_mem[in.src2];
    r.dst  = in.dst;
    r.data = {lane_ref(in.op, a[31:16], b[31:16]), lane_ref(in.op, a[15:0], b[15:0])};
    ref_mem[in.dst] = r.data;
    return r;
  endfunction

  function automatic inst_t make_inst(input op_e op, input dm_addr_t s1, input dm_addr_t s2,
                                      input dm_addr_t d);
    inst_t i;
    i.op   = op;
    i.src1 = s1;
    i.src2 = s2;
    i.dst  = d;
    return i;
  endfunction

  task automatic timed_out(input string what);
    $display("timeout, %s not seen within %0d cycles", what, WAIT_LIMIT);
    $display("ERRORS FOUND");
    $finish;
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    inst_v     <= 1'b0;   // all strobes back to idle
    res_credit <= 1'b0;
    load_v     <= 1'b0;
    xfer_v     <= 1'b0;
  endtask

  task automatic reset_core();
    rst <= 1'b1;
    inst_v     <= 1'b0;
    res_credit <= 1'b0;
    load_v     <= 1'b0;
    xfer_v     <= 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    tb_load_ptr  = '0;
    tb_xfer_ptr  = XFER_BASE;
    host_credits = INST_QDEPTH;
    exp_q.delete();
  endtask

  task automatic load_word(input data_t w);
    @(posedge clk);
    inst_v     <= 1'b0;
    res_credit <= 1'b0;
    xfer_v     <= 1'b0;
    load_v     <= 1'b1;
    load_data  <= w;
    ref_mem[tb_load_ptr] = w;
    tb_load_ptr++;   // wraps like the core pointer
  endtask

  task automatic xfer_word(input data_t w);
    @(posedge clk);
    inst_v     <= 1'b0;
    res_credit <= 1'b0;
    load_v     <= 1'b0;
    xfer_v     <= 1'b1;
    xfer_data  <= w;
    ref_mem[tb_xfer_ptr] = w;
    tb_xfer_ptr++;
  endtask

  // grant adds one result credit in the same beat
  task automatic send_inst(input inst_t in, input logic grant);
    int n;
    n = 0;
    while (host_credits == 0) begin
      idle_cycle();
      n++;
      if (n > WAIT_LIMIT) timed_out("instruction credit");
    end
    @(posedge clk);
    load_v     <= 1'b0;
    xfer_v     <= 1'b0;
    inst_v     <= 1'b1;
    inst       <= in;
    res_credit <= grant;
    host_credits--;
    exp_q.push_back(model_exec(in));
  endtask

  task automatic pulse_res_credit();
    @(posedge clk);
    inst_v     <= 1'b0;
    load_v     <= 1'b0;
    xfer_v     <= 1'b0;
    res_credit <= 1'b1;
  endtask

  task automatic wait_beats(input int target);
    int n;
    n = 0;
    while (beats < target) begin
      idle_cycle();
      n++;
      if (n > WAIT_LIMIT) timed_out("result beat");
    end
  endtask

  // all expected results out and busy low
  task automatic wait_idle();
    int n;
    n = 0;
    while (exp_q.size() != 0 || busy_s) begin
      idle_cycle();
      n++;
      if (n > WAIT_LIMIT) timed_out("idle core");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks and output monitor
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_result(input result_t exp, input result_t got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH res expected %h got %h", exp, got);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s expected %h got %h", name, exp, got);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s expected %h got %h", name, exp, got);
    end
  endtask

  // outputs are settled mid cycle
  always @(negedge clk) begin
    busy_s = busy;
    if (!rst) begin
      if (inst_credit) begin
        host_credits++;
        credit_pulses++;
      end
      if (res_v) begin
        beats++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("result beat for dst %h arrived with nothing outstanding", res.dst);
        end else begin
          check_result(exp_q.pop_front(), res);
        end
      end
    end
  end

  task automatic report_test(input string name);
    $display("test %-20s finished, error count %0d", name, errors);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_and_add();
    int start;
    start = beats;
    for (int i = 0; i < 16; i++) load_word(rand_word());   // words 0 to 15
    for (int i = 0; i < 16; i++) begin
      send_inst(make_inst(OP_ADD, dm_addr_t'(i), dm_addr_t'(15 - i), dm_addr_t'(8'h20 + i)), 1'b1);
    end
    wait_idle();
    check_count("res beats", start + 16, beats);
    report_test("load_and_add");
  endtask

  task automatic all_ops();
    dm_addr_t base;
    int       start;
    base  = tb_load_ptr;
    start = beats;
    load_word(32'hffff_8000);   // lanes at the top and the midpoint
    load_word(32'h0001_8000);
    load_word(32'h0003_00ff);
    load_word(32'hfffe_0101);
    send_inst(make_inst(OP_ADD, base, base + 1, 8'h40), 1'b1);       // both lanes wrap
    send_inst(make_inst(OP_SUB, base + 2, base + 3, 8'h41), 1'b1);   // borrow per lane
    send_inst(make_inst(OP_MUL, base, base + 3, 8'h42), 1'b1);
    send_inst(make_inst(OP_MUL, base, base, 8'h43), 1'b1);
    send_inst(make_inst(OP_MAX, base + 1, base + 3, 8'h44), 1'b1);
    send_inst(make_inst(OP_MAX, base, base + 2, 8'h45), 1'b1);
    wait_idle();
    check_count("res beats", start + 6, beats);
    report_test("all_ops");
  endtask

  // each step reads the dst written just before it
  task automatic dependency_chain();
    dm_addr_t prev;
    int       start;
    prev  = 8'h20;
    start = beats;
    for (int i = 0; i < 8; i++) begin
      send_inst(make_inst(op_e'(i % 4), prev, dm_addr_t'(i), dm_addr_t'(8'h60 + i)), 1'b1);
      prev = dm_addr_t'(8'h60 + i);
    end
    wait_idle();
    check_count("res beats", start + 8, beats);
    report_test("dependency_chain");
  endtask

  task automatic result_backpressure();
    int   start;
    logic dropped;
    start   = beats;
    dropped = 1'b0;
    for (int i = 0; i < 4; i++) begin
      send_inst(make_inst(OP_SUB, dm_addr_t'(i), dm_addr_t'(i + 4), dm_addr_t'(8'h48 + i)), 1'b0);
    end
    for (int n = 0; n < 50; n++) begin
      idle_cycle();
      if (n > 1 && !busy_s) dropped = 1'b1;
    end
    check_count("res beats", start, beats);
    check_flag("busy", 1'b1, !dropped);
    check_count("host credits", 0, host_credits);   // queue full, nothing returned
    for (int i = 0; i < 4; i++) begin
      pulse_res_credit();
      wait_beats(start + i + 1);
      repeat (8) idle_cycle();   // a second beat would show up by now
      check_count("res beats", start + i + 1, beats);
    end
    wait_idle();
    report_test("result_backpressure");
  endtask

  task automatic inst_credits();
    int start;
    start = credit_pulses;
    for (int i = 0; i < 10; i++) begin
      send_inst(make_inst(OP_MAX, dm_addr_t'(i), dm_addr_t'(8'h20 + i), dm_addr_t'(8'ha0 + i)),
                1'b1);
    end
    wait_idle();
    check_count("inst_credit pulses", 10, credit_pulses - start);
    check_count("host credits", INST_QDEPTH, host_credits);
    report_test("inst_credits");
  endtask

  task automatic xfer_and_reset();
    dm_addr_t zero_addr;
    int       start;
    zero_addr = tb_load_ptr;
    start     = beats;
    load_word('0);
    for (int i = 0; i < 4; i++) xfer_word(rand_word());   // lands at 8'h8f upward
    for (int i = 0; i < 4; i++) begin
      send_inst(make_inst(OP_ADD, XFER_BASE + i, zero_addr, dm_addr_t'(8'h70 + i)), 1'b1);
    end
    wait_idle();
    check_count("res beats", start + 4, beats);
    reset_core();
    start = beats;
    // both pointers should be back at their reset values
    load_word(rand_word());
    load_word(rand_word());
    xfer_word(rand_word());
    xfer_word(rand_word());
    send_inst(make_inst(OP_ADD, 8'h00, XFER_BASE, 8'hb0), 1'b1);
    send_inst(make_inst(OP_ADD, 8'h01, XFER_BASE + 1, 8'hb1), 1'b1);
    wait_idle();
    check_count("res beats after reset", start + 2, beats);
    check_count("host credits", INST_QDEPTH, host_credits);
    report_test("xfer_and_reset");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst           = 1'b1;
    inst_v        = 1'b0;
    inst          = '0;
    res_credit    = 1'b0;
    load_v        = 1'b0;
    load_data     = '0;
    xfer_v        = 1'b0;
    xfer_data     = '0;
    lfsr          = 32'h9b21b63d;
    errors        = 0;
    checks        = 0;
    credit_pulses = 0;
    beats         = 0;
    busy_s        = 1'b0;
    for (int i = 0; i < DM_DEPTH; i++) ref_mem[i] = '0;
    reset_core();
    load_and_add();
    all_ops();
    dependency_chain();
    result_backpressure();
    inst_credits();
    xfer_and_reset();
    $display("%0d checks, %0d errors, %0d result beats", checks, errors, beats);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire
